//--- Makefile
VERILATOR ?= verilator
TOP       ?= fctrlTb
FILELIST  ?= fctrl.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SRCS := $(shell grep -v '^+' $(FILELIST)) include/fctrl_defs.svh

.PHONY: all compile run clean

all: run

compile: $(OBJDIR)/V$(TOP)

$(OBJDIR)/V$(TOP): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "ALL CHECKS PASSED" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- fctrl.f
+incdir+include
verilog/fctrlPkg.sv
verilog/fctrlIf.sv
verilog/fctrlFields.sv
verilog/fctrlDecoder.sv
verilog/fctrlPipe.sv
verilog/fctrl.sv
sim/fctrl_assert.sv
sim/fctrlTb.sv

//--- include/fctrl_defs.svh
`ifndef FCTRL_DEFS_SVH
`define FCTRL_DEFS_SVH

//////////////////////////////////////////////////
// machine widths
//////////////////////////////////////////////////

`define FCTRL_XLEN 64 // rv64 only
`define FCTRL_CW   12 // packed decode word

//////////////////////////////////////////////////
// major opcodes, bits 6:0
//////////////////////////////////////////////////

`define FCTRL_OP_LOAD   7'b0000111 // flw/fld
`define FCTRL_OP_STORE  7'b0100111 // fsw/fsd
`define FCTRL_OP_FMADD  7'b1000011
`define FCTRL_OP_FMSUB  7'b1000111
`define FCTRL_OP_FNMSUB 7'b1001011
`define FCTRL_OP_FNMADD 7'b1001111
`define FCTRL_OP_FP     7'b1010011 // everything else

// instruction field slices
`define FCTRL_OPC_POS    6:0
`define FCTRL_FUNCT3_POS 14:12 // also the static rounding mode
`define FCTRL_RS1_POS    19:15
`define FCTRL_RS2_POS    24:20
`define FCTRL_RS3_POS    31:27 // r4-type only
`define FCTRL_FUNCT7_POS 31:25 // low two bits hold the format

// rounding modes
`define FCTRL_RM_DYN  3'b111 // take frm from the csr
`define FCTRL_RM_RSV5 3'b101
`define FCTRL_RM_RSV6 3'b110

// format field codes
`define FCTRL_FMT_S 2'b00
`define FCTRL_FMT_D 2'b01

`define FCTRL_FS_OFF 2'b00 // mstatus.fs off

`endif

//--- sim/fctrlTb.sv
`timescale 1ns/1ps
`include "fctrl_defs.svh"

module fctrlTb import fctrlPkg::*; ();

  localparam int          numTests = 40;       // directed cases, sizes the watchdog
  localparam logic [15:0] lfsrSeed = 16'hA783; // 42883
  localparam logic [15:0] lfsrTaps = 16'hB400; // x^16 + x^14 + x^13 + x^11
  localparam instrT       nopInstr = 32'h0;    // opcode 0, decodes illegal and all zero
  localparam logic [6:0]  opLd     = `FCTRL_OP_LOAD;
  localparam logic [6:0]  opSt     = `FCTRL_OP_STORE;
  localparam logic [6:0]  opMadd   = `FCTRL_OP_FMADD;
  localparam logic [6:0]  opFp     = `FCTRL_OP_FP;

  logic        clk, rstN;
  logic        stallE, stallM, stallW, flushE, flushM, flushW, fDivBusyE;
  roundModeT   frmReg;
  statusFsT    statusFs;
  instrT       instrD;
  logic        illegalFpuInstrD, xEnD, yEnD, zEnD;
  regAdrT      adr1D, adr2D, adr3D, adr1E, adr2E, adr3E;
  logic        xEnE, yEnE, zEnE, fCvtIntE, fpuActiveE, fRegWriteE, fWriteIntE, fDivStartE;
  roundModeT   frmE, frmM;
  fmtT         fmtE, fmtM;
  opCtrlT      opCtrlE, opCtrlM;
  postProcSelT postProcSelE, postProcSelM;
  fResSelT     fResSelE, fResSelM, fResSelW;
  logic        fRegWriteM, fWriteIntM, fpLoadStoreM, fRegWriteW, fCvtIntW;

  int          errorCount = 0;
  int          checkCount = 0;
  logic [15:0] lfsrState  = lfsrSeed;

  fctrl i_fctrl (.*);

  always #4 clk = ~clk; // 8 ns period

  //////////////////////////////////////////////////
  // stimulus helpers
  //////////////////////////////////////////////////

  // galois step, returns the bit shifted out
  function automatic logic nextRandBit();
    logic outBit;
    outBit    = lfsrState[0];
    lfsrState = lfsrState >> 1;
    if (outBit)
      lfsrState = lfsrState ^ lfsrTaps;
    return outBit;
  endfunction

  function automatic regAdrT randomAdr();
    regAdrT adr;
    for (int i = 0; i < 5; i++)
      adr[i] = nextRandBit(); // one step per bit
    return adr;
  endfunction

  // rd 1, rs1 3; for loads/stores funct7 and rs2 are just offset bits
  function automatic instrT rType(logic [6:0] funct7, regAdrT rs2, logic [2:0] funct3,
                                  logic [6:0] op);
    return {funct7, rs2, 5'd3, funct3, 5'd1, op};
  endfunction

  function automatic instrT r4Type(regAdrT rs3, logic [1:0] fmt, regAdrT rs2, regAdrT rs1,
                                   logic [2:0] rm, logic [6:0] op);
    return {rs3, fmt, rs2, rs1, rm, 5'd2, op};
  endfunction

  //////////////////////////////////////////////////
  // compare tasks
  //////////////////////////////////////////////////

  task automatic tallyResult(string name, logic mismatch, logic [31:0] got, logic [31:0] exp);
    checkCount++;
    if (mismatch) begin
      errorCount++;
      $display("error: %s got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  task automatic checkOpCtrl(string name, opCtrlT got, opCtrlT exp);
    tallyResult(name, got !== exp, 32'(got), 32'(exp));
  endtask
  task automatic checkFResSel(string name, fResSelT got, fResSelT exp);
    tallyResult(name, got !== exp, 32'(got), 32'(exp));
  endtask
  task automatic checkPostProcSel(string name, postProcSelT got, postProcSelT exp);
    tallyResult(name, got !== exp, 32'(got), 32'(exp));
  endtask
  task automatic checkRoundMode(string name, roundModeT got, roundModeT exp);
    tallyResult(name, got !== exp, 32'(got), 32'(exp));
  endtask
  task automatic checkRegAdr(string name, regAdrT got, regAdrT exp);
    tallyResult(name, got !== exp, 32'(got), 32'(exp));
  endtask
  task automatic checkBit(string name, logic got, logic exp);
    tallyResult(name, got !== exp, 32'(got), 32'(exp));
  endtask

  //////////////////////////////////////////////////
  // directed tests
  //////////////////////////////////////////////////

  task automatic illegalCase(instrT instr, statusFsT fs, roundModeT frm, logic exp);
    @(negedge clk);
    statusFs = fs;
    frmReg   = frm;
    instrD   = instr;
    #1; // combinational D path
    checkBit("illegalFpuInstrD", illegalFpuInstrD, exp);
  endtask

  task automatic testIllegal();
    instrT fadd;
    fadd = rType(7'h00, 5'd4, 3'b000, opFp);
    illegalCase(fadd, `FCTRL_FS_OFF, 3'b000, 1'b1);
    illegalCase(rType(7'h00, 5'd4, 3'b101, opFp), 2'b11, 3'b000, 1'b1); // reserved static
    illegalCase(rType(7'h00, 5'd4, 3'b110, opFp), 2'b11, 3'b000, 1'b1);
    for (int rm = 5; rm < 8; rm++)
      illegalCase(rType(7'h00, 5'd4, `FCTRL_RM_DYN, opFp), 2'b11, 3'(rm), 1'b1);
    illegalCase(rType(7'h02, 5'd4, 3'b000, opFp), 2'b11, 3'b000, 1'b1); // fadd.h
    illegalCase(fadd, 2'b11, 3'b000, 1'b0);
  endtask

  // key is regWrite/writeInt/fResSel/postProc/opCtrl/divStart/cvtInt, xyz the enables
  task automatic decodeCase(instrT instr, logic [10:0] key, logic [2:0] xyz, fmtT fmt,
                            logic full);
    logic        regW, wInt, div, cvt;
    fResSelT     res;
    postProcSelT pp;
    opCtrlT      opc;
    roundModeT   expFrm;
    {regW, wInt, res, pp, opc, div, cvt} = key;
    expFrm = (instr[14:12] == `FCTRL_RM_DYN) ? frmReg : instr[14:12];
    @(negedge clk);
    instrD = instr;
    #1; // enables are combinational in D
    checkBit("xEnD", xEnD, xyz[2]);
    checkBit("yEnD", yEnD, xyz[1]);
    checkBit("zEnD", zEnD, xyz[0]);
    @(negedge clk); // one unstalled edge, now in E
    checkBit("fpuActiveE", fpuActiveE, 1'b1);
    checkBit("fRegWriteE", fRegWriteE, regW);
    checkBit("fWriteIntE", fWriteIntE, wInt);
    checkBit("fCvtIntE", fCvtIntE, cvt);
    checkBit("xEnE", xEnE, xyz[2]);
    checkBit("yEnE", yEnE, xyz[1]);
    checkBit("zEnE", zEnE, xyz[0]);
    checkBit("fmtE", fmtE, fmt);
    checkRoundMode("frmE", frmE, expFrm);
    if (full) begin // only where the whole word is fixed
      checkFResSel("fResSelE", fResSelE, res);
      checkPostProcSel("postProcSelE", postProcSelE, pp);
      checkOpCtrl("opCtrlE", opCtrlE, opc);
      checkBit("fDivStartE", fDivStartE, div);
    end
    instrD = nopInstr;
    @(negedge clk); // on to M
    checkBit("fRegWriteM", fRegWriteM, regW);
    checkBit("fWriteIntM", fWriteIntM, wInt);
    checkBit("fmtM", fmtM, fmt);
    checkRoundMode("frmM", frmM, expFrm);
    if (full) begin
      checkPostProcSel("postProcSelM", postProcSelM, pp);
      checkOpCtrl("opCtrlM", opCtrlM, opc);
    end
    @(negedge clk); // and W
    checkBit("fCvtIntW", fCvtIntW, cvt);
  endtask

  task automatic testDecode();
    @(negedge clk);
    frmReg = 3'b001; // picked up by the dyn cases
    decodeCase(rType(7'h00, 5'd4, 3'b010, opLd), 11'b1_0_10_00_000_0_0, 3'b000, 1'b0, 1'b1);
    decodeCase(rType(7'h00, 5'd4, 3'b011, opSt), 11'b0_0_10_00_000_0_0, 3'b010, 1'b1, 1'b1);
    decodeCase(r4Type(5'd5, 2'b01, 5'd4, 5'd3, `FCTRL_RM_DYN, opMadd),
               11'b1_0_01_10_000_0_0, 3'b111, 1'b1, 1'b1);
    decodeCase(rType(7'h00, 5'd4, 3'b000, opFp), 11'b1_0_01_10_110_0_0, 3'b111, 1'b0, 1'b1);
    decodeCase(rType(7'h05, 5'd4, 3'b111, opFp), 11'b1_0_01_10_111_0_0, 3'b111, 1'b1, 1'b1);
    decodeCase(rType(7'h08, 5'd4, 3'b000, opFp), 11'b1_0_01_10_100_0_0, 3'b110, 1'b0, 1'b1);
    decodeCase(rType(7'h0C, 5'd4, 3'b001, opFp), 11'b1_0_01_01_000_1_0, 3'b110, 1'b0, 1'b1);
    decodeCase(rType(7'h2D, 5'd0, 3'b000, opFp), 11'b1_0_01_01_001_1_0, 3'b100, 1'b1, 1'b1);
    // compares, class, move to int, cvt to int
    decodeCase(rType(7'h50, 5'd4, 3'b010, opFp), 11'b0_1_00_00_010_0_0, 3'b110, 1'b0, 1'b1);
    decodeCase(rType(7'h51, 5'd4, 3'b001, opFp), 11'b0_1_00_00_001_0_0, 3'b110, 1'b1, 1'b1);
    decodeCase(rType(7'h50, 5'd4, 3'b000, opFp), 11'b0_1_00_00_011_0_0, 3'b110, 1'b0, 1'b1);
    decodeCase(rType(7'h70, 5'd0, 3'b001, opFp), 11'b0_1_10_00_000_0_0, 3'b100, 1'b0, 1'b1);
    decodeCase(rType(7'h70, 5'd0, 3'b000, opFp), 11'b0_1_11_00_000_0_0, 3'b100, 1'b0, 1'b1);
    decodeCase(rType(7'h60, 5'd0, 3'b001, opFp), 11'b0_1_01_00_001_0_1, 3'b100, 1'b0, 1'b1);
    // no fixed word here, enables and write flags only
    decodeCase(rType(7'h79, 5'd0, 3'b000, opFp), 11'b1_0_00_00_000_0_0, 3'b000, 1'b1, 1'b0);
    decodeCase(rType(7'h20, 5'd1, 3'b000, opFp), 11'b1_0_00_00_000_0_0, 3'b100, 1'b1, 1'b0);
    decodeCase(rType(7'h69, 5'd0, 3'b000, opFp), 11'b1_0_00_00_000_0_0, 3'b000, 1'b1, 1'b0);
    decodeCase(rType(7'h11, 5'd4, 3'b000, opFp), 11'b1_0_00_00_000_0_0, 3'b110, 1'b1, 1'b0);
    decodeCase(rType(7'h14, 5'd4, 3'b000, opFp), 11'b1_0_00_00_000_0_0, 3'b110, 1'b0, 1'b0);
  endtask

  task automatic testPipeline();
    instrT flw;
    flw = rType(7'h00, 5'd4, 3'b010, opLd);
    @(negedge clk);
    instrD = flw;
    @(negedge clk);
    instrD = nopInstr;
    checkBit("fRegWriteE", fRegWriteE, 1'b1);
    @(negedge clk);
    checkBit("fRegWriteM", fRegWriteM, 1'b1);
    checkBit("fpLoadStoreM", fpLoadStoreM, 1'b1);
    @(negedge clk);
    checkBit("fRegWriteW", fRegWriteW, 1'b1);
    checkFResSel("fResSelW", fResSelW, 2'b10);
    instrD = flw;
    @(negedge clk);           // load in E, then stall each stage in turn
    instrD = nopInstr;
    stallE = 1'b1;
    @(negedge clk);
    checkFResSel("fResSelE", fResSelE, 2'b10);
    stallE = 1'b0;
    @(negedge clk);           // E empty, load in M
    stallM = 1'b1;
    @(negedge clk);
    checkFResSel("fResSelE", fResSelE, 2'b00);
    checkFResSel("fResSelM", fResSelM, 2'b10);
    stallM = 1'b0;
    @(negedge clk);           // M empty, load in W
    stallW = 1'b1;
    @(negedge clk);
    checkFResSel("fResSelM", fResSelM, 2'b00);
    checkFResSel("fResSelW", fResSelW, 2'b10);
    stallW = 1'b0;
    instrD = flw;
    @(negedge clk);           // load in E again, now flush stage by stage
    instrD = nopInstr;
    stallE = 1'b1;
    flushE = 1'b1;            // flush beats stall
    @(negedge clk);
    checkBit("fRegWriteE", fRegWriteE, 1'b0);
    checkBit("fpuActiveE", fpuActiveE, 1'b0);
    checkBit("fRegWriteM", fRegWriteM, 1'b1);
    stallE = 1'b0;
    flushE = 1'b0;
    flushW = 1'b1;            // drops the load on its way out of M
    @(negedge clk);
    checkBit("fRegWriteW", fRegWriteW, 1'b0);
    flushW = 1'b0;
    instrD = flw;
    @(negedge clk);
    instrD = nopInstr;
    flushM = 1'b1;            // drops it on its way out of E
    @(negedge clk);
    checkBit("fRegWriteM", fRegWriteM, 1'b0);
    flushM = 1'b0;
  endtask

  task automatic testDivide();
    instrT fdiv;
    fdiv = rType(7'h0C, 5'd4, 3'b000, opFp);
    @(negedge clk);
    instrD    = fdiv;
    stallE    = 1'b1;
    fDivBusyE = 1'b1;
    @(negedge clk);
    checkBit("fDivStartE", fDivStartE, 1'b1); // loads through the stall
    fDivBusyE = 1'b0;
    instrD    = nopInstr;
    @(negedge clk);
    checkBit("fDivStartE", fDivStartE, 1'b1); // held
    stallE = 1'b0;
    @(negedge clk);
    checkBit("fDivStartE", fDivStartE, 1'b0);
    instrD = fdiv;
    stallE = 1'b1;
    @(negedge clk);
    checkBit("fDivStartE", fDivStartE, 1'b0); // held low too
    stallE = 1'b0;
  endtask

  task automatic testAddresses();
    regAdrT a1, a2, a3;
    repeat (8) begin
      a1 = randomAdr();
      a2 = randomAdr();
      a3 = randomAdr();
      @(negedge clk);
      instrD = r4Type(a3, 2'b00, a2, a1, 3'b000, opMadd);
      #1;
      checkRegAdr("adr1D", adr1D, a1);
      checkRegAdr("adr2D", adr2D, a2);
      checkRegAdr("adr3D", adr3D, a3);
      @(negedge clk);
      checkRegAdr("adr1E", adr1E, a1);
      checkRegAdr("adr2E", adr2E, a2);
      checkRegAdr("adr3E", adr3E, a3);
    end
  endtask

  //////////////////////////////////////////////////
  // sequence and watchdog
  //////////////////////////////////////////////////

  initial begin
    clk       = 1'b0;
    rstN      = 1'b0;
    stallE    = 1'b0;
    stallM    = 1'b0;
    stallW    = 1'b0;
    flushE    = 1'b0;
    flushM    = 1'b0;
    flushW    = 1'b0;
    fDivBusyE = 1'b0;
    frmReg    = 3'b000;
    statusFs  = 2'b11;   // fs dirty
    instrD    = nopInstr;
    repeat (10) @(negedge clk);
    checkBit("fRegWriteE", fRegWriteE, 1'b0);
    checkBit("fDivStartE", fDivStartE, 1'b0);
    rstN = 1'b1;
    testIllegal();
    testDecode();
    testPipeline();
    testDivide();
    testAddresses();
    errorCount += i_fctrl.i_pipeAssertions.failCount;
    $display("checks %0d errors %0d", checkCount, errorCount);
    if (errorCount == 0)
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  end

  initial begin
    #(numTests * 20 * 8);
    $display("watchdog expired before the tests finished");
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

//--- sim/fctrl_assert.sv
`timescale 1ns/1ps

module pipeAssertions import fctrlPkg::*; (
  input logic      clk,
  input logic      rstN,
  input logic      stallE, stallM, stallW,
  input logic      flushE, flushM, flushW,
  input logic      fpuActiveE, fRegWriteE, fWriteIntE, fDivStartE, fCvtIntE,
  input logic      fRegWriteM, fWriteIntM, fpLoadStoreM,
  input logic      fRegWriteW, fCvtIntW,
  input opCtrlT    opCtrlE, opCtrlM,
  input fResSelT   fResSelE, fResSelM, fResSelW,
  input roundModeT frmE
);

  int failCount = 0; // failed assertions so far

  //////////////////////////////////////////////////
  // flush and reset
  //////////////////////////////////////////////////

  aFlushE: assert property (@(posedge clk) flushE |=> !fpuActiveE)
    else begin
      failCount++;
      $error("fpuActiveE still set after flushE");
    end

  // every write enable cleared by reset
  aResetClear: assert property (@(posedge clk) !rstN |=>
      !(fRegWriteE | fRegWriteM | fRegWriteW | fWriteIntE | fWriteIntM |
        fDivStartE | fpuActiveE | fCvtIntE | fCvtIntW))
    else begin
      failCount++;
      $error("write enables not cleared by reset");
    end

  // load-store flag follows the result select that moved into M
  aLoadStoreM: assert property (@(posedge clk) disable iff (!rstN)
      !stallM && !flushM |=> fpLoadStoreM == $past(fResSelE[1]))
    else begin
      failCount++;
      $error("fpLoadStoreM differs from fResSelE[1] of the cycle before");
    end

  //////////////////////////////////////////////////
  // stall holds, fDivStartE excluded
  //////////////////////////////////////////////////

  aStallE: assert property (@(posedge clk) disable iff (!rstN) stallE && !flushE |=>
      $stable({fResSelE, opCtrlE, frmE, fRegWriteE, fWriteIntE, fpuActiveE}))
    else begin
      failCount++;
      $error("E stage moved under stall");
    end

  aStallM: assert property (@(posedge clk) disable iff (!rstN) stallM && !flushM |=>
      $stable({fResSelM, opCtrlM, fRegWriteM, fWriteIntM}))
    else begin
      failCount++;
      $error("M stage moved under stall");
    end

  aStallW: assert property (@(posedge clk) disable iff (!rstN) stallW && !flushW |=>
      $stable({fResSelW, fRegWriteW, fCvtIntW}))
    else begin
      failCount++;
      $error("W stage moved under stall");
    end

endmodule

bind fctrl pipeAssertions i_pipeAssertions (.*);

//--- verilog/fctrl.sv
`timescale 1ns/1ps

module fctrl import fctrlPkg::*; (
  input  logic        clk,
  input  logic        rstN,
  input  logic        stallE, stallM, stallW,
  input  logic        flushE, flushM, flushW,
  input  logic        fDivBusyE,     // divider still iterating
  input  roundModeT   frmReg,        // frm csr
  input  statusFsT    statusFs,      // mstatus.fs
  input  instrT       instrD,
  // decode, combinational
  output logic        illegalFpuInstrD,
  output logic        xEnD, yEnD, zEnD,
  output regAdrT      adr1D, adr2D, adr3D,
  // execute
  output logic        xEnE, yEnE, zEnE,
  output logic        fCvtIntE,
  output roundModeT   frmE,
  output fmtT         fmtE,
  output opCtrlT      opCtrlE,
  output postProcSelT postProcSelE,
  output fResSelT     fResSelE,
  output logic        fpuActiveE,
  output logic        fRegWriteE, fWriteIntE,
  output regAdrT      adr1E, adr2E, adr3E,
  output logic        fDivStartE,
  // memory
  output roundModeT   frmM,
  output fmtT         fmtM,
  output opCtrlT      opCtrlM,
  output postProcSelT postProcSelM,
  output fResSelT     fResSelM,
  output logic        fRegWriteM, fWriteIntM,
  output logic        fpLoadStoreM,
  // writeback
  output fResSelT     fResSelW,
  output logic        fRegWriteW,
  output logic        fCvtIntW
);

  fctrlFieldIf fieldBus ();  // slices and checks
  fctrlCtrlIf  ctrlBus ();   // decoded word

  fctrlFields i_fctrlFields (.instrD, .frmReg, .field(fieldBus.fields));

  fctrlDecoder i_fctrlDecoder (.statusFs, .field(fieldBus.decoder), .ctrl(ctrlBus.decoder));

  fctrlPipe i_fctrlPipe (
    .clk, .rstN, .stallE, .stallM, .stallW, .flushE, .flushM, .flushW, .fDivBusyE,
    .field(fieldBus.pipe), .ctrl(ctrlBus.pipe),
    .xEnE, .yEnE, .zEnE, .fCvtIntE, .frmE, .fmtE, .opCtrlE, .postProcSelE, .fResSelE,
    .fpuActiveE, .fRegWriteE, .fWriteIntE, .adr1E, .adr2E, .adr3E, .fDivStartE,
    .frmM, .fmtM, .opCtrlM, .postProcSelM, .fResSelM, .fRegWriteM, .fWriteIntM,
    .fpLoadStoreM, .fResSelW, .fRegWriteW, .fCvtIntW
  );

  // decode outputs straight off the buses
  assign illegalFpuInstrD = ctrlBus.illegalD;
  assign xEnD  = ctrlBus.xEnD;
  assign yEnD  = ctrlBus.yEnD;
  assign zEnD  = ctrlBus.zEnD;
  assign adr1D = fieldBus.adr1D;
  assign adr2D = fieldBus.adr2D;
  assign adr3D = fieldBus.adr3D;

endmodule

//--- verilog/fctrlDecoder.sv
`timescale 1ns/1ps
`include "fctrl_defs.svh"

module fctrlDecoder import fctrlPkg::*; (
  input  statusFsT     statusFs, // fpu off makes everything illegal
  fctrlFieldIf.decoder field,
  fctrlCtrlIf.decoder  ctrl
);

  localparam logic isRv64 = (`FCTRL_XLEN == 64); // l/lu cvt and fmv of doubles

  logic [`FCTRL_CW-1:0] ctrlD;  // packed decode word
  logic        fRegWrite, fWriteInt, fDivStart, illegal, fCvtInt;
  fResSelT     fResSel;
  postProcSelT postProcSel;
  opCtrlT      opCtrl;
  logic        loadStore;
  logic        fpuOn;
  logic        mvToFp;          // fmv.w.x / fmv.d.x
  logic        cvtToFp;         // int to fp conversion
  logic        isCvt;           // any conversion, int or fp
  logic        isSqrt;
  logic        mvFmtOk;         // fmv of a double needs rv64

  assign loadStore = (field.op == `FCTRL_OP_LOAD) | (field.op == `FCTRL_OP_STORE);
  assign fpuOn     = (statusFs != `FCTRL_FS_OFF);
  assign mvFmtOk   = (field.funct3 == 3'b000) & (field.rs2 == 5'b00000) &
                     (~field.funct7[0] | isRv64);

  //////////////////////////////////////////////////
  // decode table
  //////////////////////////////////////////////////

  // word layout: regWrite_writeInt_fResSel_postProc_opCtrl_divStart_illegal_cvtInt
  always_comb begin
    ctrlD = `FCTRL_CW'b0_0_00_00_000_0_1_0;  // default illegal, rest zero
    // non-memory ops need a real format and rounding mode
    if (fpuOn && (loadStore || (field.fmtOk && field.rmOk))) begin
      case (field.op)
        `FCTRL_OP_LOAD:
          if (field.funct3 == 3'b010 || field.funct3 == 3'b011)
            ctrlD = `FCTRL_CW'b1_0_10_00_000_0_0_0;       // flw/fld
        `FCTRL_OP_STORE:
          if (field.funct3 == 3'b010 || field.funct3 == 3'b011)
            ctrlD = `FCTRL_CW'b0_0_10_00_000_0_0_0;       // fsw/fsd
        `FCTRL_OP_FMADD:  ctrlD = `FCTRL_CW'b1_0_01_10_000_0_0_0;
        `FCTRL_OP_FMSUB:  ctrlD = `FCTRL_CW'b1_0_01_10_001_0_0_0;
        `FCTRL_OP_FNMSUB: ctrlD = `FCTRL_CW'b1_0_01_10_010_0_0_0;
        `FCTRL_OP_FNMADD: ctrlD = `FCTRL_CW'b1_0_01_10_011_0_0_0;
        `FCTRL_OP_FP: casez (field.funct7)
          7'b00000??: ctrlD = `FCTRL_CW'b1_0_01_10_110_0_0_0;   // fadd
          7'b00001??: ctrlD = `FCTRL_CW'b1_0_01_10_111_0_0_0;   // fsub
          7'b00010??: ctrlD = `FCTRL_CW'b1_0_01_10_100_0_0_0;   // fmul
          7'b00011??: ctrlD = `FCTRL_CW'b1_0_01_01_000_1_0_0;   // fdiv
          7'b01011??: if (field.rs2 == 5'b00000)
                        ctrlD = `FCTRL_CW'b1_0_01_01_001_1_0_0; // fsqrt
          7'b00100??: case (field.funct3)
                        3'b000: ctrlD = `FCTRL_CW'b1_0_00_00_000_0_0_0; // fsgnj
                        3'b001: ctrlD = `FCTRL_CW'b1_0_00_00_001_0_0_0; // fsgnjn
                        3'b010: ctrlD = `FCTRL_CW'b1_0_00_00_010_0_0_0; // fsgnjx
                        default: ;
                      endcase
          7'b00101??: case (field.funct3)
                        3'b000: ctrlD = `FCTRL_CW'b1_0_00_00_110_0_0_0; // fmin
                        3'b001: ctrlD = `FCTRL_CW'b1_0_00_00_101_0_0_0; // fmax
                        default: ;
                      endcase
          7'b10100??: case (field.funct3)
                        3'b000: ctrlD = `FCTRL_CW'b0_1_00_00_011_0_0_0; // fle
                        3'b001: ctrlD = `FCTRL_CW'b0_1_00_00_001_0_0_0; // flt
                        3'b010: ctrlD = `FCTRL_CW'b0_1_00_00_010_0_0_0; // feq
                        default: ;
                      endcase
          7'b11100??: if (field.funct3 == 3'b001 && field.rs2 == 5'b00000)
                        ctrlD = `FCTRL_CW'b0_1_10_00_000_0_0_0;         // fclass
                      else if (mvFmtOk)
                        ctrlD = `FCTRL_CW'b0_1_11_00_000_0_0_0;         // fmv.x.w/d
          7'b11110??: if (mvFmtOk)
                        ctrlD = `FCTRL_CW'b1_0_00_00_011_0_0_0;         // fmv.w/d.x
          7'b0100000: if (field.rs2 == 5'b00001)
                        ctrlD = `FCTRL_CW'b1_0_01_00_000_0_0_0;         // fcvt.s.d
          7'b0100001: if (field.rs2 == 5'b00000)
                        ctrlD = `FCTRL_CW'b1_0_01_00_001_0_0_0;         // fcvt.d.s
          7'b110100?: case (field.rs2)                                  // int -> s/d
                        5'b00000: ctrlD = `FCTRL_CW'b1_0_01_00_101_0_0_0;
                        5'b00001: ctrlD = `FCTRL_CW'b1_0_01_00_100_0_0_0;
                        5'b00010: if (isRv64) ctrlD = `FCTRL_CW'b1_0_01_00_111_0_0_0;
                        5'b00011: if (isRv64) ctrlD = `FCTRL_CW'b1_0_01_00_110_0_0_0;
                        default: ;
                      endcase
          7'b110000?: case (field.rs2)                                  // s/d -> int
                        5'b00000: ctrlD = `FCTRL_CW'b0_1_01_00_001_0_0_1;
                        5'b00001: ctrlD = `FCTRL_CW'b0_1_01_00_000_0_0_1;
                        5'b00010: if (isRv64) ctrlD = `FCTRL_CW'b0_1_01_00_011_0_0_1;
                        5'b00011: if (isRv64) ctrlD = `FCTRL_CW'b0_1_01_00_010_0_0_1;
                        default: ;
                      endcase
          default: ;
        endcase
        default: ;
      endcase
    end
  end

  assign {fRegWrite, fWriteInt, fResSel, postProcSel, opCtrl, fDivStart, illegal,
          fCvtInt} = ctrlD;

  //////////////////////////////////////////////////
  // source enables
  //////////////////////////////////////////////////

  assign mvToFp  = (fResSel == 2'b00) & fRegWrite & (opCtrl == 3'b011);
  assign isCvt   = (fResSel == 2'b01) & (postProcSel == 2'b00);
  assign cvtToFp = isCvt & opCtrl[2];
  assign isSqrt  = (fResSel == 2'b01) & (postProcSel == 2'b01) & opCtrl[0];

  assign ctrl.xEnD = ~(((fResSel == 2'b10) & ~fWriteInt) | mvToFp | cvtToFp); // no X for mem
  assign ctrl.yEnD = ~(((fResSel == 2'b10) & (fWriteInt | fRegWrite)) |    // load, class
                       mvToFp |
                       ((fResSel == 2'b11) & (postProcSel == 2'b00)) |      // mv to int
                       isCvt | isSqrt);
  assign ctrl.zEnD = (postProcSel == 2'b10) & (~opCtrl[2] | opCtrl[1]);    // fma, add, sub

  assign ctrl.fRegWriteD   = fRegWrite;
  assign ctrl.fWriteIntD   = fWriteInt;
  assign ctrl.fResSelD     = fResSel;
  assign ctrl.postProcSelD = postProcSel;
  assign ctrl.opCtrlD      = opCtrl;
  assign ctrl.fDivStartD   = fDivStart;
  assign ctrl.fCvtIntD     = fCvtInt;
  assign ctrl.illegalD     = illegal;

endmodule

//--- verilog/fctrlFields.sv
`timescale 1ns/1ps
`include "fctrl_defs.svh"

module fctrlFields import fctrlPkg::*; (
  input  instrT       instrD,  // instruction in decode
  input  roundModeT   frmReg,  // frm from the csr
  fctrlFieldIf.fields field
);

  logic       cvtFpFp;    // fcvt.s.d or fcvt.d.s
  logic       loadStore;
  logic [1:0] fmtSel;     // 2-bit format before reduction to fmtT
  logic       dynRm;      // funct3 asks for dynamic rounding
  logic       frmBad;     // csr holds a reserved or dyn code

  //////////////////////////////////////////////////
  // field slices
  //////////////////////////////////////////////////

  assign field.op     = instrD[`FCTRL_OPC_POS];
  assign field.funct3 = instrD[`FCTRL_FUNCT3_POS];
  assign field.funct7 = instrD[`FCTRL_FUNCT7_POS];
  assign field.rs2    = instrD[`FCTRL_RS2_POS];

  // source addresses, used for hazards even if the op ignores them
  assign field.adr1D = instrD[`FCTRL_RS1_POS];
  assign field.adr2D = instrD[`FCTRL_RS2_POS];
  assign field.adr3D = instrD[`FCTRL_RS3_POS];

  //////////////////////////////////////////////////
  // rounding mode
  //////////////////////////////////////////////////

  assign dynRm  = (field.funct3 == `FCTRL_RM_DYN);
  assign frmBad = (frmReg == `FCTRL_RM_RSV5) | (frmReg == `FCTRL_RM_RSV6) |
                  (frmReg == `FCTRL_RM_DYN);

  assign field.frmD = dynRm ? frmReg : field.funct3;

  // 101/110 reserved statically, dyn is only as good as frm
  assign field.rmOk = ~((field.funct3 == `FCTRL_RM_RSV5) |
                        (field.funct3 == `FCTRL_RM_RSV6) |
                        (dynRm & frmBad));

  //////////////////////////////////////////////////
  // format
  //////////////////////////////////////////////////

  // funct7 = 010000x, OP-FP, rs2 names the source format
  assign cvtFpFp   = (field.funct7[6:3] == 4'b0100) & field.op[4] & ~field.rs2[2];
  assign loadStore = (field.op == `FCTRL_OP_LOAD) | (field.op == `FCTRL_OP_STORE);

  always_comb begin
    if (cvtFpFp)
      fmtSel = field.rs2[1:0];                     // source of fp-to-fp cvt
    else if (loadStore)
      fmtSel = (field.funct3 == 3'b011) ? `FCTRL_FMT_D : `FCTRL_FMT_S; // width code
    else
      fmtSel = field.funct7[1:0];
  end

  assign field.fmtD = (fmtSel == `FCTRL_FMT_D); // 1 = double

  // only S and D exist, H and Q fall out here
  assign field.fmtOk = (field.funct7[1:0] == `FCTRL_FMT_S) |
                       (field.funct7[1:0] == `FCTRL_FMT_D);

endmodule

//--- verilog/fctrlIf.sv
`timescale 1ns/1ps

// instruction fields, from fctrlFields
interface fctrlFieldIf import fctrlPkg::*; ();
  logic [6:0] op;      // major opcode
  logic [2:0] funct3;
  logic [6:0] funct7;
  regAdrT     rs2;     // also selects cvt variants
  fmtT        fmtD;
  roundModeT  frmD;    // resolved rounding mode
  logic       fmtOk, rmOk;
  regAdrT     adr1D, adr2D, adr3D;

  modport fields  (output op, funct3, funct7, rs2, fmtD, frmD, fmtOk, rmOk,
                   adr1D, adr2D, adr3D);
  modport decoder (input op, funct3, funct7, rs2, fmtOk, rmOk);
  modport pipe    (input fmtD, frmD, adr1D, adr2D, adr3D);
endinterface

// decoded control word, decoder to pipe
interface fctrlCtrlIf import fctrlPkg::*; ();
  logic        fRegWriteD, fWriteIntD;
  fResSelT     fResSelD;
  postProcSelT postProcSelD;
  opCtrlT      opCtrlD;
  logic        fDivStartD, fCvtIntD, illegalD;
  logic        xEnD, yEnD, zEnD; // source operand enables

  modport decoder (output fRegWriteD, fWriteIntD, fResSelD, postProcSelD, opCtrlD,
                   fDivStartD, fCvtIntD, illegalD, xEnD, yEnD, zEnD);
  modport pipe    (input fRegWriteD, fWriteIntD, fResSelD, postProcSelD, opCtrlD,
                   fDivStartD, fCvtIntD, illegalD, xEnD, yEnD, zEnD);
endinterface

//--- verilog/fctrlPipe.sv
`timescale 1ns/1ps

module fctrlPipe import fctrlPkg::*; (
  input  logic        clk,
  input  logic        rstN,
  input  logic        stallE, stallM, stallW,
  input  logic        flushE, flushM, flushW,  // flush wins over stall
  input  logic        fDivBusyE,
  fctrlFieldIf.pipe   field,
  fctrlCtrlIf.pipe    ctrl,
  // execute
  output logic        xEnE, yEnE, zEnE,
  output logic        fCvtIntE,
  output roundModeT   frmE,
  output fmtT         fmtE,
  output opCtrlT      opCtrlE,
  output postProcSelT postProcSelE,
  output fResSelT     fResSelE,
  output logic        fpuActiveE,
  output logic        fRegWriteE, fWriteIntE,
  output regAdrT      adr1E, adr2E, adr3E,
  output logic        fDivStartE,
  // memory
  output roundModeT   frmM,
  output fmtT         fmtM,
  output opCtrlT      opCtrlM,
  output postProcSelT postProcSelM,
  output fResSelT     fResSelM,
  output logic        fRegWriteM, fWriteIntM,
  output logic        fpLoadStoreM,
  // writeback
  output fResSelT     fResSelW,
  output logic        fRegWriteW,
  output logic        fCvtIntW
);

  logic fCvtIntM;  // carried only to reach W

  //////////////////////////////////////////////////
  // D/E
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstN || flushE) begin
      {fRegWriteE, fWriteIntE, fResSelE, postProcSelE, opCtrlE, frmE, fmtE} <= '0;
      {fCvtIntE, fpuActiveE, xEnE, yEnE, zEnE} <= '0;
      {adr1E, adr2E, adr3E} <= '0;
    end else if (!stallE) begin
      {fRegWriteE, fWriteIntE, fResSelE} <= {ctrl.fRegWriteD, ctrl.fWriteIntD, ctrl.fResSelD};
      {postProcSelE, opCtrlE}            <= {ctrl.postProcSelD, ctrl.opCtrlD};
      {frmE, fmtE}                       <= {field.frmD, field.fmtD};
      fCvtIntE   <= ctrl.fCvtIntD;
      fpuActiveE <= ~ctrl.illegalD;   // legal fp op now in E
      {xEnE, yEnE, zEnE}    <= {ctrl.xEnD, ctrl.yEnD, ctrl.zEnD};
      {adr1E, adr2E, adr3E} <= {field.adr1D, field.adr2D, field.adr3D};
    end
  end

  // keeps loading while the divider is busy, even under stall
  always_ff @(posedge clk) begin
    if (!rstN || flushE)
      fDivStartE <= 1'b0;
    else if (!stallE || fDivBusyE)
      fDivStartE <= ctrl.fDivStartD;
  end

  //////////////////////////////////////////////////
  // E/M
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstN || flushM) begin
      {fRegWriteM, fWriteIntM, fResSelM, postProcSelM, opCtrlM, frmM, fmtM} <= '0;
      fCvtIntM <= 1'b0;
    end else if (!stallM) begin
      {fRegWriteM, fWriteIntM, fResSelM} <= {fRegWriteE, fWriteIntE, fResSelE};
      {postProcSelM, opCtrlM, frmM, fmtM} <= {postProcSelE, opCtrlE, frmE, fmtE};
      fCvtIntM <= fCvtIntE;
    end
  end

  assign fpLoadStoreM = fResSelM[1];  // 10 load-store, 11 never leaves the int side

  //////////////////////////////////////////////////
  // M/W
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstN || flushW)
      {fRegWriteW, fResSelW, fCvtIntW} <= '0;
    else if (!stallW)
      {fRegWriteW, fResSelW, fCvtIntW} <= {fRegWriteM, fResSelM, fCvtIntM};
  end

endmodule

//--- verilog/fctrlPkg.sv
package fctrlPkg;

  //////////////////////////////////////////////////
  // decode stage inputs
  //////////////////////////////////////////////////

  typedef logic [31:0] instrT;   // raw instruction word
  typedef logic [4:0]  regAdrT;  // fp register file address
  typedef logic [2:0]  roundModeT; // static or resolved rounding mode
  typedef logic [1:0]  statusFsT;  // mstatus.fs

  // 0 single, 1 double
  typedef logic fmtT;

  //////////////////////////////////////////////////
  // control fields
  //////////////////////////////////////////////////

  // unit-specific op select
  // fma: {not fmadd, neg product, neg addend}
  // cmp: {eq, lt} in low bits, min 110 / max 101
  // cvt int: {int to fp, 64-bit int, signed}
  typedef logic [2:0] opCtrlT;

  // final result select
  // fp side 00 other / 01 postproc / 10 load-store
  // int side 00 cmp / 01 cvt / 10 class / 11 mv
  typedef logic [1:0] fResSelT;

  // post processing select, 00 cvt / 01 div / 10 fma
  typedef logic [1:0] postProcSelT;

endpackage
